/* Makefile */
# Verilator flow for the texture cache testbench
VERILATOR ?= verilator
FILELIST ?= texCacheTop.f
TB_TOP ?= texCacheTb
RTL_TOP ?= texCacheTop
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert
BUILD_FLAGS ?= -j 0
PASS_TEXT ?= RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) $(BUILD_FLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(OBJ_DIR)

# the run passes only if the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* source/cacheReadIf.sv */
/*
	cache read port
	one lookup stage asks for an entry index, the store answers
	next cycle with the stored tag, line and valid flag
*/
`timescale 1ns/1ns

interface cacheReadIf;

	// requested entry, sampled by the store on every clock
	texCachePkg::indexT readIndex;

	// registered contents of that entry, one cycle later
	texCachePkg::tagT readTag;
	texCachePkg::lineT readLine;
	logic readValid;

	// lookup side
	modport stage (output readIndex, input readTag, input readLine, input readValid);

	// storage side
	modport store (input readIndex, output readTag, output readLine, output readValid);

endinterface

/* source/cacheStore.sv */
/*
	texture cache storage
	holds line, tag and valid bit for every entry, fills entries by
	spying 64-bit writes to texture memory, and serves two lookup
	ports with registered reads so the arrays map onto block RAM
*/
`timescale 1ns/1ns
`include "texCache_cfg.svh"

module cacheStore (
	input logic clk,
	input logic reset,
	input logic clearCache,

	// spied texture memory write
	input logic textureFormatTrueColor,
	input logic write,
	input texCachePkg::wordAddrT writeAddr,
	input texCachePkg::lineT writeData,

	cacheReadIf.store portA,
	cacheReadIf.store portB
);

	// write address after the block remap
	texCachePkg::wordAddrT writeMapped;
	texCachePkg::indexT writeIndex;
	texCachePkg::tagT writeTag;

	// line and tag arrays, no reset so they can sit in RAM
	texCachePkg::lineT lineMem [`TEX_ENTRIES];
	texCachePkg::tagT tagMem [`TEX_ENTRIES];

	// one valid flag per entry, kept in flops for a single-cycle clear
	logic [`TEX_ENTRIES-1:0] validVec;

	// same remap as the lookup side, otherwise a word would never be found
	assign writeMapped = texCachePkg::swizzle(writeAddr, textureFormatTrueColor);

	// low bits pick the entry
	assign writeIndex = writeMapped[`TEX_INDEX_W-1:0];
	// what is left above the index tells entries apart
	assign writeTag = writeMapped[`TEX_WORD_ADDR_W-1:`TEX_INDEX_W];

	// fill on every spied write
	// an entry is simply overwritten, direct mapped
	always_ff @(posedge clk) begin
		if (write) begin
			lineMem[writeIndex] <= writeData;
			tagMem[writeIndex] <= writeTag;
		end
	end

	// valid flags
	// clear beats a write landing on the same edge
	always_ff @(posedge clk) begin
		if (reset || clearCache) begin
			validVec <= '0;
		end else if (write) begin
			validVec[writeIndex] <= 1'b1;
		end
	end

	// read ports
	// nonblocking reads see the contents from before this edge,
	// so a write to the same entry shows up one cycle later
	always_ff @(posedge clk) begin
		portA.readLine <= lineMem[portA.readIndex];
		portA.readTag <= tagMem[portA.readIndex];
		portB.readLine <= lineMem[portB.readIndex];
		portB.readTag <= tagMem[portB.readIndex];
	end

	// valid flag travels with the read data
	// cleared on reset so no stale hit comes out after power-up
	always_ff @(posedge clk) begin
		if (reset) begin
			portA.readValid <= 1'b0;
			portB.readValid <= 1'b0;
		end else begin
			portA.readValid <= validVec[portA.readIndex];
			portB.readValid <= validVec[portB.readIndex];
		end
	end

	// a spied write must carry a known address or the wrong entry fills
	assert property (@(posedge clk) disable iff (reset)
		write |-> !$isunknown(writeAddr));

	// lookups issued on the edge after a clear come back empty on both ports
	assert property (@(posedge clk)
		$past(reset || clearCache) |=> (!portA.readValid && !portB.readValid));

endmodule

/* source/lookupStage.sv */
/*
	texel lookup stage
	remaps the word part of a texel address, asks the store for that
	entry, then one cycle later checks the tag and valid flag and
	picks the wanted halfword out of the returned line
*/
`timescale 1ns/1ns
`include "texCache_cfg.svh"

module lookupStage (
	input logic clk,
	input logic textureFormatTrueColor,
	input texCachePkg::lookAddrT lookAddr,
	output texCachePkg::pixelT dataOut,
	output logic isHit,
	cacheReadIf.stage store
);

	// split of the texel address
	texCachePkg::wordAddrT lookWord;
	texCachePkg::halfSelT lookHalf;

	// remapped word address for this format
	texCachePkg::wordAddrT lookMapped;

	// lookup in flight, waiting for the store
	texCachePkg::tagT expTag;
	texCachePkg::halfSelT pendHalf;

	// upper bits address a 64-bit word
	assign lookWord = lookAddr[`TEX_LOOK_ADDR_W-1:`TEX_LOOK_ADDR_W-`TEX_WORD_ADDR_W];
	// low bits pick one of four texels in it
	assign lookHalf = lookAddr[`TEX_LOOK_ADDR_W-`TEX_WORD_ADDR_W-1:0];

	// must match the remap used when the line was written
	assign lookMapped = texCachePkg::swizzle(lookWord, textureFormatTrueColor);

	// index goes out straight away, the store registers it
	assign store.readIndex = lookMapped[`TEX_INDEX_W-1:0];

	// keep what is needed to judge the answer next cycle
	// no reset, isHit is qualified by the store's valid flag
	always_ff @(posedge clk) begin
		expTag <= lookMapped[`TEX_WORD_ADDR_W-1:`TEX_INDEX_W];
		pendHalf <= lookHalf;
	end

	// hit only when the entry is filled and holds this very word
	assign isHit = store.readValid && (store.readTag == expTag);

	// halfword select, texel 0 sits in the low bits of the line
	always_comb begin
		dataOut = store.readLine[pendHalf * `TEX_PIXEL_W +: `TEX_PIXEL_W];
	end

	// a reported hit must deliver real data from the store
	assert property (@(posedge clk)
		isHit |-> !$isunknown(dataOut));

endmodule

/* source/texCachePkg.sv */
/*
	texture cache types
	vector types for addresses, tags, lines and texels, plus the
	format-dependent address swizzle shared by the write spy and
	the lookup ports
*/
`include "texCache_cfg.svh"

package texCachePkg;

	// word address on the 64-bit texture bus
	typedef logic [`TEX_WORD_ADDR_W-1:0] wordAddrT;
	// texel address, word address plus halfword select
	typedef logic [`TEX_LOOK_ADDR_W-1:0] lookAddrT;

	// entry index and the tag above it, both taken from the swizzled address
	typedef logic [`TEX_INDEX_W-1:0] indexT;
	typedef logic [`TEX_WORD_ADDR_W-`TEX_INDEX_W-1:0] tagT;

	typedef logic [`TEX_LINE_W-1:0] lineT;
	typedef logic [`TEX_PIXEL_W-1:0] pixelT;

	// which halfword of the line a lookup wants
	typedef logic [`TEX_LOOK_ADDR_W-`TEX_WORD_ADDR_W-1:0] halfSelT;

	// remap a word address so that a small 2D block of texels
	// lands in distinct entries instead of one long scan line
	// 16 bpp keeps 5 column bits and 5 row bits in the low part
	// 8/4 bpp keeps 6 column bits and 6 row bits in the low part
	function automatic wordAddrT swizzle(input wordAddrT addr, input logic trueColor);
		wordAddrT mapped;
		if (trueColor) begin
			// page, column, row, word within row
			mapped = {addr[16:13], addr[7:3], addr[12:8], addr[2:0]};
		end else begin
			// page, column, row, word within row, narrower page
			mapped = {addr[16:14], addr[7:2], addr[13:8], addr[1:0]};
		end
		return mapped;
	endfunction

endpackage

/* source/texCacheTop.sv */
/*
	texture cache top
	direct-mapped cache that spies on texture memory writes and
	answers two independent texel lookups per clock, each with a
	fixed latency of one cycle
*/
`timescale 1ns/1ns

module texCacheTop (
	input logic clk,
	input logic reset,
	input logic clearCache,

	// texture memory write spy
	input logic textureFormatTrueColor,
	input logic write,
	input texCachePkg::wordAddrT writeAddr,
	input texCachePkg::lineT writeData,

	// lookup port A
	input texCachePkg::lookAddrT lookAddrA,
	output texCachePkg::pixelT dataOutA,
	output logic isHitA,

	// lookup port B
	input texCachePkg::lookAddrT lookAddrB,
	output texCachePkg::pixelT dataOutB,
	output logic isHitB
);

	// one read port of the store per lookup stage
	cacheReadIf readA ();
	cacheReadIf readB ();

	// shared storage, filled by the write spy
	cacheStore u_store (
		.clk(clk),
		.reset(reset),
		.clearCache(clearCache),
		.textureFormatTrueColor(textureFormatTrueColor),
		.write(write),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.portA(readA.store),
		.portB(readB.store)
	);

	// both stages use the current format, same as the write side
	lookupStage lookA (
		.clk(clk),
		.textureFormatTrueColor(textureFormatTrueColor),
		.lookAddr(lookAddrA),
		.dataOut(dataOutA),
		.isHit(isHitA),
		.store(readA.stage)
	);

	lookupStage lookB (
		.clk(clk),
		.textureFormatTrueColor(textureFormatTrueColor),
		.lookAddr(lookAddrB),
		.dataOut(dataOutB),
		.isHit(isHitB),
		.store(readB.stage)
	);

endmodule

/* source/texCache_cfg.svh */
/*
	texture cache configuration
	widths of the texture memory addresses, the line and the texel,
	and the index width that sets the cache size
*/
`ifndef TEX_CACHE_CFG_SVH
`define TEX_CACHE_CFG_SVH

// 64-bit word address into 1 MB of texture memory
`define TEX_WORD_ADDR_W 17
// halfword address as seen by the texel fetch
`define TEX_LOOK_ADDR_W 19

// entry index width, 8 gives the 2 KB cache and 9 the 4 KB one
`define TEX_INDEX_W 8
// entry count follows the index width
`define TEX_ENTRIES (1 << `TEX_INDEX_W)

// one cache line holds one spied memory word
`define TEX_LINE_W 64
`define TEX_PIXEL_W 16

`endif

/* tb/tbClock.sv */
/*
	testbench clock and reset
	free-running 10 ns clock, reset held high for the first
	16 cycles and released on a falling edge
*/
`timescale 1ns/1ns

module tbClock (
	output logic clk,
	output logic reset
);

	localparam int HALF_PERIOD = 5;
	localparam int RESET_CYCLES = 16;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// release away from the rising edge so the DUT sees a clean level
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

/* tb/texCacheTb.sv */
/*
	texture cache testbench
	drives the write spy and both lookup ports on falling edges,
	keeps its own model of tags, lines and valid flags, and checks
	both ports one cycle after every lookup
*/
`timescale 1ns/1ns
`include "texCache_cfg.svh"

module texCacheTb;

	// about 2700 cycles of tests, leave generous headroom
	localparam int TIMEOUT_CYCLES = 5000;
	localparam int RANDOM_CYCLES = 2500;

	logic clk;
	logic reset;
	logic clearCache;
	logic textureFormatTrueColor;
	logic write;
	texCachePkg::wordAddrT writeAddr;
	texCachePkg::lineT writeData;
	texCachePkg::lookAddrT lookAddrA;
	texCachePkg::pixelT dataOutA;
	logic isHitA;
	texCachePkg::lookAddrT lookAddrB;
	texCachePkg::pixelT dataOutB;
	logic isHitB;

	// model state, one entry per cache index
	texCachePkg::tagT modelTag [`TEX_ENTRIES];
	texCachePkg::lineT modelLine [`TEX_ENTRIES];
	logic modelValid [`TEX_ENTRIES];

	// expected {hit, texel}, set at the drive edge, moved on at the rising edge
	logic nextEn;
	logic [`TEX_PIXEL_W:0] nextExpA;
	logic [`TEX_PIXEL_W:0] nextExpB;
	logic pendEn;
	logic [`TEX_PIXEL_W:0] pendExpA;
	logic [`TEX_PIXEL_W:0] pendExpB;

	int seed;
	int cycleCount;
	int errCount;
	int checkCount;
	int testCount;
	int testFails;
	int testErrStart;
	string curTest;

	tbClock clockGen (
		.clk(clk),
		.reset(reset)
	);

	texCacheTop u_dut (
		.clk(clk),
		.reset(reset),
		.clearCache(clearCache),
		.textureFormatTrueColor(textureFormatTrueColor),
		.write(write),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.lookAddrA(lookAddrA),
		.dataOutA(dataOutA),
		.isHitA(isHitA),
		.lookAddrB(lookAddrB),
		.dataOutB(dataOutB),
		.isHitB(isHitB)
	);

	function automatic logic [31:0] randWord();
		return $random(seed);
	endfunction

	// random word address anywhere in texture memory
	function automatic texCachePkg::wordAddrT randAddr();
		logic [31:0] r;
		r = randWord();
		return r[`TEX_WORD_ADDR_W-1:0];
	endfunction

	// block remap as the format rules describe it, msb first
	function automatic texCachePkg::wordAddrT remapWord(input texCachePkg::wordAddrT a,
			input logic trueColor);
		if (trueColor) begin
			return {a[16:13], a[7:3], a[12:8], a[2:0]};
		end
		return {a[16:14], a[7:2], a[13:8], a[1:0]};
	endfunction

	// expected {hit, texel} for a lookup against the current model
	function automatic logic [`TEX_PIXEL_W:0] expectLookup(input texCachePkg::lookAddrT addr,
			input logic fmt);
		texCachePkg::wordAddrT mapped;
		texCachePkg::indexT idx;
		int half;
		logic hit;
		texCachePkg::pixelT texel;
		mapped = remapWord(addr[`TEX_LOOK_ADDR_W-1:`TEX_LOOK_ADDR_W-`TEX_WORD_ADDR_W], fmt);
		idx = mapped[`TEX_INDEX_W-1:0];
		half = int'(addr[1:0]);
		hit = modelValid[idx] && (modelTag[idx] == mapped[`TEX_WORD_ADDR_W-1:`TEX_INDEX_W]);
		// texel 0 in the low bits of the line
		texel = hit ? modelLine[idx][half * `TEX_PIXEL_W +: `TEX_PIXEL_W] : '0;
		return {hit, texel};
	endfunction

	// what the coming rising edge does to the store
	task automatic applyToModel(input logic doWrite, input texCachePkg::wordAddrT addr,
			input texCachePkg::lineT data, input logic doClear, input logic fmt);
		texCachePkg::wordAddrT mapped;
		texCachePkg::indexT idx;
		mapped = remapWord(addr, fmt);
		idx = mapped[`TEX_INDEX_W-1:0];
		if (doWrite) begin
			modelLine[idx] = data;
			modelTag[idx] = mapped[`TEX_WORD_ADDR_W-1:`TEX_INDEX_W];
		end
		// clear wins over a write on the same edge
		if (doClear) begin
			for (int i = 0; i < `TEX_ENTRIES; i++) begin
				modelValid[i] = 1'b0;
			end
		end else if (doWrite) begin
			modelValid[idx] = 1'b1;
		end
	endtask

	// one clock, called on a falling edge, returns on the next one
	task automatic runCycle(input logic doWrite, input texCachePkg::wordAddrT wAddr,
			input texCachePkg::lineT wData, input logic doClear, input logic fmt,
			input logic doLook, input texCachePkg::lookAddrT aAddr,
			input texCachePkg::lookAddrT bAddr);
		write = doWrite;
		writeAddr = wAddr;
		writeData = wData;
		clearCache = doClear;
		textureFormatTrueColor = fmt;
		lookAddrA = aAddr;
		lookAddrB = bAddr;
		// lookups see the contents from before this edge
		nextEn = doLook;
		nextExpA = expectLookup(aAddr, fmt);
		nextExpB = expectLookup(bAddr, fmt);
		applyToModel(doWrite, wAddr, wData, doClear, fmt);
		@(negedge clk);
	endtask

	task automatic writeLine(input logic fmt, input texCachePkg::wordAddrT addr,
			input texCachePkg::lineT data);
		runCycle(1'b1, addr, data, 1'b0, fmt, 1'b0, '0, '0);
	endtask

	task automatic lookPair(input logic fmt, input texCachePkg::lookAddrT aAddr,
			input texCachePkg::lookAddrT bAddr);
		runCycle(1'b0, '0, '0, 1'b0, fmt, 1'b1, aAddr, bAddr);
	endtask

	task automatic startTest(input string name);
		curTest = name;
		testErrStart = errCount;
	endtask

	// two idle cycles let the last result reach the compare process
	task automatic finishTest();
		int newErr;
		runCycle(1'b0, '0, '0, 1'b0, textureFormatTrueColor, 1'b0, '0, '0);
		runCycle(1'b0, '0, '0, 1'b0, textureFormatTrueColor, 1'b0, '0, '0);
		newErr = errCount - testErrStart;
		testCount++;
		if (newErr == 0) begin
			$display("test %s: ok", curTest);
		end else begin
			testFails++;
			$display("test %s: %0d errors", curTest, newErr);
		end
	endtask

	task automatic checkPort(input string port, input logic hit, input texCachePkg::pixelT texel,
			input logic [`TEX_PIXEL_W:0] exp);
		checkCount++;
		assert (hit === exp[`TEX_PIXEL_W]) else begin
			$display("ERR %s port %s hit: expected %0b actual %0b",
				curTest, port, exp[`TEX_PIXEL_W], hit);
			errCount++;
		end
		// texel only matters on a hit
		if (exp[`TEX_PIXEL_W]) begin
			checkCount++;
			assert (texel === exp[`TEX_PIXEL_W-1:0]) else begin
				$display("ERR %s port %s texel: expected %h actual %h",
					curTest, port, exp[`TEX_PIXEL_W-1:0], texel);
				errCount++;
			end
		end
	endtask

	always @(posedge clk) begin
		pendEn <= nextEn;
		pendExpA <= nextExpA;
		pendExpB <= nextExpB;
	end

	// outputs settle after the rising edge, sample them mid-cycle
	always @(negedge clk) begin
		if (pendEn) begin
			checkPort("A", isHitA, dataOutA, pendExpA);
			checkPort("B", isHitB, dataOutB, pendExpB);
		end
	end

	task automatic testResetMiss();
		logic [31:0] r;
		for (int i = 0; i < 8; i++) begin
			r = randWord();
			lookPair(r[0], r[18:0], {r[31:19], r[5:0]});
		end
	endtask

	task automatic testFillRead();
		texCachePkg::wordAddrT addr;
		texCachePkg::lineT data;
		int hb;
		for (int f = 0; f < 2; f++) begin
			addr = randAddr();
			data = {randWord(), randWord()};
			writeLine(f[0], addr, data);
			for (int h = 0; h < 4; h++) begin
				hb = 3 - h;
				lookPair(f[0], {addr, h[1:0]}, {addr, hb[1:0]});
			end
		end
	endtask

	// bit 16 sits in the tag in both formats, so the index stays the same
	task automatic testEviction();
		texCachePkg::wordAddrT a1;
		texCachePkg::wordAddrT a2;
		for (int f = 0; f < 2; f++) begin
			a1 = randAddr();
			a2 = a1 ^ 17'h10000;
			writeLine(f[0], a1, {randWord(), randWord()});
			writeLine(f[0], a2, {randWord(), randWord()});
			lookPair(f[0], {a1, 2'd0}, {a2, 2'd1});
			lookPair(f[0], {a2, 2'd3}, {a1, 2'd2});
		end
	endtask

	task automatic testSameCycle();
		texCachePkg::wordAddrT a;
		texCachePkg::wordAddrT b;
		a = randAddr();
		b = a ^ 17'h00100;
		writeLine(1'b1, a, {randWord(), randWord()});
		// old line this cycle, new line the next
		runCycle(1'b1, a, {randWord(), randWord()}, 1'b0, 1'b1, 1'b1, {a, 2'd0}, {a, 2'd3});
		lookPair(1'b1, {a, 2'd0}, {a, 2'd3});
		runCycle(1'b1, b, {randWord(), randWord()}, 1'b0, 1'b1, 1'b1, {b, 2'd1}, {b, 2'd2});
		lookPair(1'b1, {b, 2'd1}, {b, 2'd2});
	endtask

	task automatic testClear();
		texCachePkg::wordAddrT addrs [16];
		for (int i = 0; i < 16; i++) begin
			addrs[i] = randAddr();
			writeLine(1'b0, addrs[i], {randWord(), randWord()});
		end
		// lookups on the clear edge still read the old flags
		runCycle(1'b0, '0, '0, 1'b1, 1'b0, 1'b1, {addrs[0], 2'd0}, {addrs[1], 2'd1});
		for (int i = 0; i < 16; i += 2) begin
			lookPair(1'b0, {addrs[i], 2'd2}, {addrs[i + 1], 2'd3});
		end
		// a write on the clear edge is lost
		runCycle(1'b1, addrs[0], {randWord(), randWord()}, 1'b1, 1'b0, 1'b0, '0, '0);
		lookPair(1'b0, {addrs[0], 2'd0}, {addrs[0], 2'd1});
		for (int i = 0; i < 16; i++) begin
			writeLine(1'b0, addrs[i], {randWord(), randWord()});
		end
		for (int i = 0; i < 16; i += 2) begin
			lookPair(1'b0, {addrs[i], 2'd1}, {addrs[i + 1], 2'd2});
		end
	endtask

	// small address pool so that lookups hit often
	task automatic testRandomMix();
		texCachePkg::wordAddrT pool [32];
		logic [31:0] r;
		logic fmt;
		for (int i = 0; i < 32; i++) begin
			pool[i] = randAddr();
		end
		fmt = 1'b0;
		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			r = randWord();
			if (r[5:3] == 3'd0) begin
				fmt = ~fmt;
			end
			runCycle(r[0], pool[r[12:8]], {randWord(), randWord()}, r[31:24] == 8'd0, fmt,
				r[1], {pool[r[20:16]], r[22:21]}, {pool[r[27:23]], r[7:6]});
		end
	endtask

	initial begin
		cycleCount = 0;
		while (cycleCount < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		seed = 32'h37910f0a;
		errCount = 0;
		checkCount = 0;
		testCount = 0;
		testFails = 0;
		testErrStart = 0;
		curTest = "reset";
		clearCache = 1'b0;
		textureFormatTrueColor = 1'b0;
		write = 1'b0;
		writeAddr = '0;
		writeData = '0;
		lookAddrA = '0;
		lookAddrB = '0;
		nextEn = 1'b0;
		nextExpA = '0;
		nextExpB = '0;
		// reset leaves every entry empty
		for (int i = 0; i < `TEX_ENTRIES; i++) begin
			modelValid[i] = 1'b0;
			modelTag[i] = '0;
			modelLine[i] = '0;
		end
		wait (reset == 1'b1);
		wait (reset == 1'b0);

		startTest("reset miss");
		testResetMiss();
		finishTest();
		startTest("fill and read");
		testFillRead();
		finishTest();
		startTest("eviction");
		testEviction();
		finishTest();
		startTest("same cycle write");
		testSameCycle();
		finishTest();
		startTest("clear");
		testClear();
		finishTest();
		startTest("random mix");
		testRandomMix();
		finishTest();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			testCount, testFails, checkCount, errCount);
		if (errCount == 0 && testFails == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* texCacheTop.f */
+incdir+source
source/texCachePkg.sv
source/cacheReadIf.sv
source/cacheStore.sv
source/lookupStage.sv
source/texCacheTop.sv
tb/tbClock.sv
tb/texCacheTb.sv
